//--- run.sh
#!/bin/sh
# Compile and run the execution pipeline testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=rv_exec_pipeline_sim

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f \
    --top-module rv_exec_pipeline_tb \
    -Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" "$LOG"; then
    exit 1
fi
if ! grep -q "All tests passed!" "$LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0

//--- sim.f
+incdir+src
src/rv_core_pkg.sv
src/rv_decoder.sv
src/rv_reg_file.sv
src/rv_alu.sv
src/rv_csr_unit.sv
src/rv_exec_pipeline.sv
testbench/rv_exec_pipeline_tb.sv

//--- src/rv_alu.sv
`timescale 1ns/100ps

module rv_alu
    import rv_core_pkg::*;
(
    input  alu_op_t op,
    input  xlen_t   a,
    input  xlen_t   b,
    output xlen_t   result
);

    logic [4:0] shamt;

    // only the low five bits shift, as in rv32
    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_SLL:    result = a << shamt;
            ALU_SLT:    result = xlen_t'($signed(a) < $signed(b));
            ALU_SLTU:   result = xlen_t'(a < b);
            ALU_XOR:    result = a ^ b;
            ALU_SRL:    result = a >> shamt;
            ALU_SRA:    result = xlen_t'($signed(a) >>> shamt);
            ALU_OR:     result = a | b;
            ALU_AND:    result = a & b;
            ALU_PASS_B: result = b;
            default:    result = '0;
        endcase
    end

endmodule

//--- src/rv_core_pkg.sv
`include "rv_core_settings.svh"

package rv_core_pkg;

    // -------------------------------------------------------------------------
    // plain vectors
    // -------------------------------------------------------------------------
    typedef logic [`RV_XLEN-1:0]               xlen_t;
    typedef logic [31:0]                       inst_t;
    typedef logic [$clog2(`RV_REG_COUNT)-1:0]  reg_addr_t;
    typedef logic [11:0]                       csr_addr_t;

    // -------------------------------------------------------------------------
    // operation encodings
    // -------------------------------------------------------------------------
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_t;

    typedef enum logic [1:0] {
        CSR_OP_NONE,
        CSR_OP_ASSIGN,
        CSR_OP_SET,
        CSR_OP_CLEAR
    } csr_op_t;

    // -------------------------------------------------------------------------
    // stage payloads
    // -------------------------------------------------------------------------
    typedef struct packed {
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        alu_op_t   alu_op;
        logic      b_is_imm;
        logic      a_is_zero;
        logic      rd_we;
        csr_op_t   csr_op;
        logic      csr_uimm;   // rs1 field is a 5-bit zero-extended source
        csr_addr_t csr_addr;
        logic      illegal;
    } decoded_t;

    typedef struct packed {
        decoded_t dec;
        xlen_t    rs1_data;
        xlen_t    rs2_data;
        xlen_t    imm;
    } exe_stage_t;

    typedef struct packed {
        reg_addr_t rd;
        xlen_t     data;
        logic      rd_we;
        logic      illegal;
    } retire_t;

endpackage

//--- src/rv_core_settings.svh
`ifndef RV_CORE_SETTINGS_SVH
`define RV_CORE_SETTINGS_SVH

// datapath and register file size
`define RV_XLEN      32
`define RV_REG_COUNT 32

// major opcodes kept by this core
`define RV_OPCODE_OP     7'b0110011
`define RV_OPCODE_OP_IMM 7'b0010011
`define RV_OPCODE_LUI    7'b0110111
`define RV_OPCODE_SYSTEM 7'b1110011

// funct7 for the base and the alternate (sub/sra) encodings
`define RV_FUNCT7_BASE 7'b0000000
`define RV_FUNCT7_ALT  7'b0100000

// integer funct3
`define RV_F3_ADD_SUB 3'b000
`define RV_F3_SLL     3'b001
`define RV_F3_SLT     3'b010
`define RV_F3_SLTU    3'b011
`define RV_F3_XOR     3'b100
`define RV_F3_SRL_SRA 3'b101
`define RV_F3_OR      3'b110
`define RV_F3_AND     3'b111

// csr funct3, bit 2 marks the immediate forms
`define RV_F3_CSRRW  3'b001
`define RV_F3_CSRRS  3'b010
`define RV_F3_CSRRC  3'b011
`define RV_F3_CSRRWI 3'b101
`define RV_F3_CSRRSI 3'b110
`define RV_F3_CSRRCI 3'b111

// csr addresses
`define RV_CSR_MSCRATCH  12'h340
`define RV_CSR_MCYCLE    12'hB00
`define RV_CSR_MINSTRET  12'hB02
`define RV_CSR_MCYCLEH   12'hB80
`define RV_CSR_MINSTRETH 12'hB82

`endif

//--- src/rv_csr_unit.sv
`timescale 1ns/100ps

`include "rv_core_settings.svh"

module rv_csr_unit
    import rv_core_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  csr_op_t   op,
    input  csr_addr_t addr,
    input  xlen_t     src,
    input  logic      commit,
    output xlen_t     rdata
);

    logic [2*`RV_XLEN-1:0] mcycle;
    logic [2*`RV_XLEN-1:0] minstret;
    xlen_t                 mscratch;
    xlen_t                 wdata;
    logic                  wr_en;

    // -------------------------------------------------------------------------
    // read side
    // -------------------------------------------------------------------------
    always_comb begin
        case (addr)
            `RV_CSR_MCYCLE:    rdata = mcycle[`RV_XLEN-1:0];
            `RV_CSR_MCYCLEH:   rdata = mcycle[2*`RV_XLEN-1:`RV_XLEN];
            `RV_CSR_MINSTRET:  rdata = minstret[`RV_XLEN-1:0];
            `RV_CSR_MINSTRETH: rdata = minstret[2*`RV_XLEN-1:`RV_XLEN];
            `RV_CSR_MSCRATCH:  rdata = mscratch;
            default:           rdata = '0;
        endcase
    end

    // -------------------------------------------------------------------------
    // write side
    // -------------------------------------------------------------------------
    // set and clear work on the value being read
    always_comb begin
        case (op)
            CSR_OP_ASSIGN: wdata = src;
            CSR_OP_SET:    wdata = rdata | src;
            CSR_OP_CLEAR:  wdata = rdata & ~src;
            default:       wdata = rdata;
        endcase
    end

    assign wr_en = commit && (op != CSR_OP_NONE);

    always_ff @(posedge clk) begin
        if (rst) begin
            mscratch <= '0;
        end else if (wr_en && (addr == `RV_CSR_MSCRATCH)) begin
            mscratch <= wdata;
        end
    end

    // a write to either half holds the counter for that cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle <= '0;
        end else if (wr_en && (addr == `RV_CSR_MCYCLE)) begin
            mcycle[`RV_XLEN-1:0] <= wdata;
        end else if (wr_en && (addr == `RV_CSR_MCYCLEH)) begin
            mcycle[2*`RV_XLEN-1:`RV_XLEN] <= wdata;
        end else begin
            mcycle <= mcycle + 1'b1;
        end
    end

    // counts every instruction leaving execute
    always_ff @(posedge clk) begin
        if (rst) begin
            minstret <= '0;
        end else if (wr_en && (addr == `RV_CSR_MINSTRET)) begin
            minstret[`RV_XLEN-1:0] <= wdata;
        end else if (wr_en && (addr == `RV_CSR_MINSTRETH)) begin
            minstret[2*`RV_XLEN-1:`RV_XLEN] <= wdata;
        end else if (commit) begin
            minstret <= minstret + 1'b1;
        end
    end

    // an instruction leaving execute carries a defined csr operation
    assert property (@(posedge clk) disable iff (rst)
        commit |-> !$isunknown(op))
        else $error("csr operation unknown while execute advances");

endmodule

//--- src/rv_decoder.sv
`timescale 1ns/100ps

`include "rv_core_settings.svh"

module rv_decoder
    import rv_core_pkg::*;
(
    input  inst_t    inst,
    output decoded_t decoded,
    output xlen_t    imm
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       bad;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // shared by register and immediate forms, alt selects sub/sra
    function automatic alu_op_t alu_op_for(input logic [2:0] f3, input logic alt);
        alu_op_t op;
        case (f3)
            `RV_F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
            `RV_F3_SLL:     op = ALU_SLL;
            `RV_F3_SLT:     op = ALU_SLT;
            `RV_F3_SLTU:    op = ALU_SLTU;
            `RV_F3_XOR:     op = ALU_XOR;
            `RV_F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
            `RV_F3_OR:      op = ALU_OR;
            default:        op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        decoded          = '0;
        decoded.rs1      = inst[19:15];
        decoded.rs2      = inst[24:20];
        decoded.rd       = inst[11:7];
        decoded.alu_op   = ALU_ADD;
        decoded.csr_op   = CSR_OP_NONE;
        decoded.csr_addr = inst[31:20];
        imm              = {{20{inst[31]}}, inst[31:20]};
        bad              = 1'b0;

        case (opcode)
            `RV_OPCODE_OP: begin
                decoded.rd_we  = 1'b1;
                decoded.alu_op = alu_op_for(funct3, funct7[5]);
                // alternate funct7 only exists for sub and sra
                if (funct7 == `RV_FUNCT7_ALT) begin
                    bad = (funct3 != `RV_F3_ADD_SUB) && (funct3 != `RV_F3_SRL_SRA);
                end else begin
                    bad = (funct7 != `RV_FUNCT7_BASE);
                end
            end
            `RV_OPCODE_OP_IMM: begin
                decoded.rd_we    = 1'b1;
                decoded.b_is_imm = 1'b1;
                decoded.alu_op   = alu_op_for(funct3,
                                              (funct3 == `RV_F3_SRL_SRA) && funct7[5]);
                if (funct3 == `RV_F3_SLL) begin
                    imm = {27'b0, inst[24:20]};
                    bad = (funct7 != `RV_FUNCT7_BASE);
                end else if (funct3 == `RV_F3_SRL_SRA) begin
                    imm = {27'b0, inst[24:20]};
                    bad = (funct7 != `RV_FUNCT7_BASE) && (funct7 != `RV_FUNCT7_ALT);
                end
            end
            `RV_OPCODE_LUI: begin
                decoded.rd_we     = 1'b1;
                decoded.b_is_imm  = 1'b1;
                decoded.a_is_zero = 1'b1;
                decoded.alu_op    = ALU_PASS_B;
                imm               = {inst[31:12], 12'b0};
            end
            `RV_OPCODE_SYSTEM: begin
                decoded.rd_we    = 1'b1;
                decoded.csr_uimm = funct3[2];
                case (funct3)
                    `RV_F3_CSRRW, `RV_F3_CSRRWI: decoded.csr_op = CSR_OP_ASSIGN;
                    `RV_F3_CSRRS, `RV_F3_CSRRSI: decoded.csr_op = CSR_OP_SET;
                    `RV_F3_CSRRC, `RV_F3_CSRRCI: decoded.csr_op = CSR_OP_CLEAR;
                    default:                     bad = 1'b1;  // ecall, ebreak and friends
                endcase
            end
            default: bad = 1'b1;
        endcase

        // anything unknown retires as a no-op with the flag up
        if (bad) begin
            decoded.illegal = 1'b1;
            decoded.rd_we   = 1'b0;
            decoded.csr_op  = CSR_OP_NONE;
        end
    end

endmodule

//--- src/rv_exec_pipeline.sv
`timescale 1ns/100ps

module rv_exec_pipeline
    import rv_core_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    in_valid,
    input  inst_t   in_inst,
    output logic    in_ready,
    output logic    ret_valid,
    input  logic    ret_ready,
    output retire_t ret
);

    decoded_t   decoded;
    xlen_t      imm;
    xlen_t      rs1_data;
    xlen_t      rs2_data;
    logic       advance;
    logic       rf_we;

    exe_stage_t exe_q;
    logic       exe_valid;
    logic       wb_valid;
    retire_t    wb_q;

    logic       fwd_a;
    logic       fwd_b;
    xlen_t      op_a;
    xlen_t      op_b;
    xlen_t      alu_a;
    xlen_t      alu_b;
    xlen_t      alu_result;
    xlen_t      csr_src;
    xlen_t      csr_rdata;
    logic       is_csr;
    logic       csr_commit;
    retire_t    wb_next;

    // -------------------------------------------------------------------------
    // flow control
    // -------------------------------------------------------------------------
    // everything moves together unless writeback is held
    assign advance   = ret_ready || !wb_valid;
    assign in_ready  = advance;
    assign ret_valid = wb_valid;
    assign ret       = wb_q;
    assign rf_we     = wb_valid && ret_ready && wb_q.rd_we;

    // -------------------------------------------------------------------------
    // decode
    // -------------------------------------------------------------------------
    rv_decoder rv_decoder_inst (
        .inst    (in_inst),
        .decoded (decoded),
        .imm     (imm)
    );

    rv_reg_file rv_reg_file_inst (
        .clk     (clk),
        .rst     (rst),
        .we      (rf_we),
        .waddr   (wb_q.rd),
        .wdata   (wb_q.data),
        .raddr_a (decoded.rs1),
        .raddr_b (decoded.rs2),
        .rdata_a (rs1_data),
        .rdata_b (rs2_data)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            exe_valid <= 1'b0;
            wb_valid  <= 1'b0;
        end else if (advance) begin
            exe_valid <= in_valid;
            wb_valid  <= exe_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && in_valid) begin
            exe_q.dec      <= decoded;
            exe_q.rs1_data <= rs1_data;
            exe_q.rs2_data <= rs2_data;
            exe_q.imm      <= imm;
        end
    end

    // -------------------------------------------------------------------------
    // execute
    // -------------------------------------------------------------------------
    // the writeback result is not in the register file yet
    assign fwd_a = wb_valid && wb_q.rd_we && (wb_q.rd != '0) && (wb_q.rd == exe_q.dec.rs1);
    assign fwd_b = wb_valid && wb_q.rd_we && (wb_q.rd != '0) && (wb_q.rd == exe_q.dec.rs2);

    assign op_a  = fwd_a ? wb_q.data : exe_q.rs1_data;
    assign op_b  = fwd_b ? wb_q.data : exe_q.rs2_data;
    assign alu_a = exe_q.dec.a_is_zero ? '0 : op_a;
    assign alu_b = exe_q.dec.b_is_imm ? exe_q.imm : op_b;

    rv_alu rv_alu_inst (
        .op     (exe_q.dec.alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result)
    );

    // immediate csr forms reuse the rs1 field as uimm
    assign csr_src    = exe_q.dec.csr_uimm ? xlen_t'(exe_q.dec.rs1) : op_a;
    assign is_csr     = (exe_q.dec.csr_op != CSR_OP_NONE);
    assign csr_commit = exe_valid && advance;

    rv_csr_unit rv_csr_unit_inst (
        .clk    (clk),
        .rst    (rst),
        .op     (exe_q.dec.csr_op),
        .addr   (exe_q.dec.csr_addr),
        .src    (csr_src),
        .commit (csr_commit),
        .rdata  (csr_rdata)
    );

    always_comb begin
        wb_next.rd      = exe_q.dec.rd;
        wb_next.data    = is_csr ? csr_rdata : alu_result;
        wb_next.rd_we   = exe_q.dec.rd_we;
        wb_next.illegal = exe_q.dec.illegal;
    end

    // -------------------------------------------------------------------------
    // writeback
    // -------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (advance && exe_valid) begin
            wb_q <= wb_next;
        end
    end

    // retire port holds its item until the consumer takes it
    assert property (@(posedge clk) disable iff (rst)
        (ret_valid && !ret_ready) |=> (ret_valid && $stable(ret)))
        else $error("retire item changed while held by back-pressure");

endmodule

//--- src/rv_reg_file.sv
`timescale 1ns/100ps

`include "rv_core_settings.svh"

module rv_reg_file
    import rv_core_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      we,
    input  reg_addr_t waddr,
    input  xlen_t     wdata,
    input  reg_addr_t raddr_a,
    input  reg_addr_t raddr_b,
    output xlen_t     rdata_a,
    output xlen_t     rdata_b
);

    // x0 has no storage
    xlen_t regs [1:`RV_REG_COUNT-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // -------------------------------------------------------------------------
    // read ports with write-through
    // -------------------------------------------------------------------------
    always_comb begin
        if (raddr_a == '0) begin
            rdata_a = '0;
        end else if (we && (waddr == raddr_a)) begin
            rdata_a = wdata;
        end else begin
            rdata_a = regs[raddr_a];
        end
    end

    always_comb begin
        if (raddr_b == '0) begin
            rdata_b = '0;
        end else if (we && (waddr == raddr_b)) begin
            rdata_b = wdata;
        end else begin
            rdata_b = regs[raddr_b];
        end
    end

    // a write needs a known target
    assert property (@(posedge clk) disable iff (rst)
        we |-> !$isunknown(waddr))
        else $error("register write with an unknown address");

endmodule

//--- testbench/rv_exec_pipeline_tb.sv
`timescale 1ns/100ps

`include "rv_core_settings.svh"

module rv_exec_pipeline_tb
    import rv_core_pkg::*;
;

    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 8;
    localparam int CYCLES_PER_OP = 20;

    // how the data field of a retired item is judged
    typedef enum logic [1:0] {
        CHECK_EXACT,
        CHECK_RECORD,
        CHECK_LATER,
        CHECK_NONE
    } data_check_t;

    typedef struct packed {
        inst_t       inst;
        reg_addr_t   rd;
        xlen_t       data;
        logic        rd_we;
        logic        illegal;
        data_check_t check;
    } entry_t;

    logic    clk;
    logic    rst;
    logic    in_valid;
    inst_t   in_inst;
    logic    in_ready;
    logic    ret_valid;
    logic    ret_ready;
    retire_t ret;

    entry_t  table_q[$];
    entry_t  exp_e;
    int      ret_idx;
    int      error_count;
    xlen_t   first_cycle;
    integer  seed;

    rv_exec_pipeline rv_exec_pipeline_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_inst   (in_inst),
        .in_ready  (in_ready),
        .ret_valid (ret_valid),
        .ret_ready (ret_ready),
        .ret       (ret)
    );

    // ------------------------------------------------------------------------
    // instruction encoders
    // ------------------------------------------------------------------------
    function automatic inst_t r_type(input logic [6:0] f7, input int rs2, input int rs1,
                                     input logic [2:0] f3, input int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), `RV_OPCODE_OP};
    endfunction

    function automatic inst_t i_type(input logic [11:0] imm, input int rs1,
                                     input logic [2:0] f3, input int rd,
                                     input logic [6:0] opcode);
        return {imm, 5'(rs1), f3, 5'(rd), opcode};
    endfunction

    function automatic inst_t u_type(input logic [19:0] imm, input int rd);
        return {imm, 5'(rd), `RV_OPCODE_LUI};
    endfunction

    function automatic inst_t csr_type(input csr_addr_t addr, input int rs1,
                                       input logic [2:0] f3, input int rd);
        return {addr, 5'(rs1), f3, 5'(rd), `RV_OPCODE_SYSTEM};
    endfunction

    task automatic add_entry(input inst_t inst, input int rd, input xlen_t data,
                             input logic rd_we, input logic illegal,
                             input data_check_t check);
        entry_t e;
        e.inst    = inst;
        e.rd      = 5'(rd);
        e.data    = data;
        e.rd_we   = rd_we;
        e.illegal = illegal;
        e.check   = check;
        table_q.push_back(e);
    endtask

    // ------------------------------------------------------------------------
    // stimulus table, expected values by hand from the rv32i rules
    // ------------------------------------------------------------------------
    task automatic build_table();
        // x1 = 5, x2 = -3
        add_entry(i_type(12'd5, 0, `RV_F3_ADD_SUB, 1, `RV_OPCODE_OP_IMM), 1, 32'd5, 1, 0, CHECK_EXACT);
        add_entry(i_type(12'hFFD, 0, `RV_F3_ADD_SUB, 2, `RV_OPCODE_OP_IMM), 2, 32'hFFFFFFFD, 1, 0, CHECK_EXACT);
        add_entry(r_type(`RV_FUNCT7_BASE, 2, 1, `RV_F3_ADD_SUB, 3), 3, 32'd2, 1, 0, CHECK_EXACT);
        add_entry(r_type(`RV_FUNCT7_ALT, 2, 1, `RV_F3_ADD_SUB, 4), 4, 32'd8, 1, 0, CHECK_EXACT);
        add_entry(r_type(`RV_FUNCT7_BASE, 2, 1, `RV_F3_AND, 5), 5, 32'd5, 1, 0, CHECK_EXACT);
        add_entry(r_type(`RV_FUNCT7_BASE, 2, 1, `RV_F3_OR, 6), 6, 32'hFFFFFFFD, 1, 0, CHECK_EXACT);
        add_entry(r_type(`RV_FUNCT7_BASE, 2, 1, `RV_F3_XOR, 7), 7, 32'hFFFFFFF8, 1, 0, CHECK_EXACT);
        add_entry(r_type(`RV_FUNCT7_BASE, 1, 2, `RV_F3_SLT, 8), 8, 32'd1, 1, 0, CHECK_EXACT);
        add_entry(r_type(`RV_FUNCT7_BASE, 1, 2, `RV_F3_SLTU, 9), 9, 32'd0, 1, 0, CHECK_EXACT);
        add_entry(r_type(`RV_FUNCT7_BASE, 4, 1, `RV_F3_SLL, 10), 10, 32'h00000500, 1, 0, CHECK_EXACT);
        add_entry(r_type(`RV_FUNCT7_BASE, 1, 2, `RV_F3_SRL_SRA, 11), 11, 32'h07FFFFFF, 1, 0, CHECK_EXACT);
        add_entry(r_type(`RV_FUNCT7_ALT, 1, 2, `RV_F3_SRL_SRA, 12), 12, 32'hFFFFFFFF, 1, 0, CHECK_EXACT);
        // dependent chain through forwarding and the bypass
        add_entry(u_type(20'h12345, 13), 13, 32'h12345000, 1, 0, CHECK_EXACT);
        add_entry(i_type(12'h404, 13, `RV_F3_SRL_SRA, 14, `RV_OPCODE_OP_IMM), 14, 32'h01234500, 1, 0, CHECK_EXACT);
        add_entry(i_type(12'd1, 14, `RV_F3_ADD_SUB, 15, `RV_OPCODE_OP_IMM), 15, 32'h01234501, 1, 0, CHECK_EXACT);
        add_entry(r_type(`RV_FUNCT7_BASE, 14, 15, `RV_F3_ADD_SUB, 16), 16, 32'h02468A01, 1, 0, CHECK_EXACT);
        add_entry(i_type(12'hFFE, 2, `RV_F3_SLT, 17, `RV_OPCODE_OP_IMM), 17, 32'd1, 1, 0, CHECK_EXACT);
        add_entry(i_type(12'hFFF, 2, `RV_F3_SLTU, 18, `RV_OPCODE_OP_IMM), 18, 32'd1, 1, 0, CHECK_EXACT);
        // x0 keeps zero even right after a write to it
        add_entry(i_type(12'd7, 1, `RV_F3_ADD_SUB, 0, `RV_OPCODE_OP_IMM), 0, 32'd12, 1, 0, CHECK_EXACT);
        add_entry(r_type(`RV_FUNCT7_BASE, 1, 0, `RV_F3_ADD_SUB, 19), 19, 32'd5, 1, 0, CHECK_EXACT);
        // mscratch goes 0, 5, 13, 8, 31
        add_entry(csr_type(`RV_CSR_MSCRATCH, 1, `RV_F3_CSRRW, 20), 20, 32'd0, 1, 0, CHECK_EXACT);
        add_entry(csr_type(`RV_CSR_MSCRATCH, 4, `RV_F3_CSRRS, 21), 21, 32'd5, 1, 0, CHECK_EXACT);
        add_entry(csr_type(`RV_CSR_MSCRATCH, 1, `RV_F3_CSRRC, 22), 22, 32'd13, 1, 0, CHECK_EXACT);
        add_entry(csr_type(`RV_CSR_MSCRATCH, 31, `RV_F3_CSRRWI, 23), 23, 32'd8, 1, 0, CHECK_EXACT);
        add_entry(csr_type(`RV_CSR_MSCRATCH, 0, `RV_F3_CSRRS, 24), 24, 32'd31, 1, 0, CHECK_EXACT);
        // every earlier entry has left execute, so the old count is the index
        add_entry(csr_type(`RV_CSR_MINSTRET, 0, `RV_F3_CSRRW, 0), 0, xlen_t'(table_q.size()),
                  1, 0, CHECK_EXACT);
        add_entry(i_type(12'd1, 0, `RV_F3_ADD_SUB, 25, `RV_OPCODE_OP_IMM), 25, 32'd1, 1, 0, CHECK_EXACT);
        add_entry(i_type(12'd2, 0, `RV_F3_ADD_SUB, 26, `RV_OPCODE_OP_IMM), 26, 32'd2, 1, 0, CHECK_EXACT);
        add_entry(csr_type(`RV_CSR_MINSTRET, 0, `RV_F3_CSRRS, 27), 27, 32'd2, 1, 0, CHECK_EXACT);
        // two mcycle reads with one op between
        add_entry(csr_type(`RV_CSR_MCYCLE, 0, `RV_F3_CSRRS, 28), 28, 32'd0, 1, 0, CHECK_RECORD);
        add_entry(i_type(12'd3, 0, `RV_F3_ADD_SUB, 29, `RV_OPCODE_OP_IMM), 29, 32'd3, 1, 0, CHECK_EXACT);
        add_entry(csr_type(`RV_CSR_MCYCLE, 0, `RV_F3_CSRRS, 30), 30, 32'd0, 1, 0, CHECK_LATER);
        // a load is outside the kept set
        add_entry(i_type(12'd0, 1, 3'b010, 31, 7'b0000011), 31, 32'd0, 0, 1, CHECK_NONE);
        add_entry(i_type(12'd0, 31, `RV_F3_ADD_SUB, 1, `RV_OPCODE_OP_IMM), 1, 32'd0, 1, 0, CHECK_EXACT);
    endtask

    // holds valid until the DUT takes the word
    task automatic send_inst(input inst_t inst);
        logic taken;
        taken    = 1'b0;
        in_valid = 1'b1;
        in_inst  = inst;
        while (!taken) begin
            @(negedge clk);
            taken = in_ready;
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // random back-pressure on the retire port
    initial begin
        seed      = 5;
        ret_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            ret_ready = (($random(seed) & 3) != 0);
        end
    end

    // ------------------------------------------------------------------------
    // retire monitor
    // ------------------------------------------------------------------------
    initial begin
        ret_idx     = 0;
        error_count = 0;
        first_cycle = '0;
        forever begin
            @(negedge clk);
            if (!rst && ret_valid && ret_ready) begin
                if (ret_idx >= table_q.size()) begin
                    $display("Error at %0t ns: an item retired beyond the end of the table",
                             $time);
                    error_count++;
                end else begin
                    exp_e = table_q[ret_idx];
                    if (ret.rd !== exp_e.rd) begin
                        $display("Error at %0t ns: item %0d ret.rd expected %h, got %h",
                                 $time, ret_idx, exp_e.rd, ret.rd);
                        error_count++;
                    end
                    if (ret.rd_we !== exp_e.rd_we) begin
                        $display("Error at %0t ns: item %0d ret.rd_we expected %b, got %b",
                                 $time, ret_idx, exp_e.rd_we, ret.rd_we);
                        error_count++;
                    end
                    if (ret.illegal !== exp_e.illegal) begin
                        $display("Error at %0t ns: item %0d ret.illegal expected %b, got %b",
                                 $time, ret_idx, exp_e.illegal, ret.illegal);
                        error_count++;
                    end
                    if (exp_e.check == CHECK_EXACT && ret.data !== exp_e.data) begin
                        $display("Error at %0t ns: item %0d ret.data expected %h, got %h",
                                 $time, ret_idx, exp_e.data, ret.data);
                        error_count++;
                    end
                    if (exp_e.check == CHECK_RECORD) begin
                        first_cycle = ret.data;
                    end
                    if (exp_e.check == CHECK_LATER &&
                        ($isunknown(ret.data) || !(ret.data > first_cycle))) begin
                        $display("Error at %0t ns: item %0d ret.data expected above %h, got %h",
                                 $time, ret_idx, first_cycle, ret.data);
                        error_count++;
                    end
                end
                ret_idx++;
            end
        end
    end

    // run limit scales with the table
    initial begin
        @(negedge rst);
        #(CLK_PERIOD * CYCLES_PER_OP * table_q.size());
        $display("timeout: %0d of %0d items retired", ret_idx, table_q.size());
        $display("Test failures found");
        $finish;
    end

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        rst      = 1'b1;
        in_valid = 1'b0;
        in_inst  = '0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        foreach (table_q[i]) begin
            send_inst(table_q[i].inst);
        end
        in_valid = 1'b0;
        while (ret_idx < table_q.size()) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        $display("checked %0d items, %0d errors", ret_idx, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
